//--- source/nx_pkg.sv
// ####################
// Shared types, widths and APB register map
// for the mesh node egress stage
// ####################

package nx_pkg;

    // Coordinate, payload and counter widths
    localparam int NX_COORD_W    = 4;
    localparam int NX_PAYLOAD_W  = 24;
    localparam int NX_CNT_W      = 16;
    localparam int NX_APB_DATA_W = 32;
    localparam int NX_NUM_DIRS   = 4;

    // Egress directions in clockwise order
    typedef enum logic [1:0] {
        NX_DIRX_NORTH = 2'd0,
        NX_DIRX_EAST  = 2'd1,
        NX_DIRX_SOUTH = 2'd2,
        NX_DIRX_WEST  = 2'd3
    } nx_direction_t;

    // Message as carried on every stream
    typedef struct packed {
        logic [NX_COORD_W-1:0]   tgt_row;
        logic [NX_COORD_W-1:0]   tgt_col;
        logic [NX_PAYLOAD_W-1:0] payload;
    } nx_message_t;

    // Register offsets
    // Position holds row in the low nibble and column above it
    localparam int unsigned NX_REG_POS    = 'h00;
    localparam int unsigned NX_REG_SENT_N = 'h04;
    localparam int unsigned NX_REG_SENT_E = 'h08;
    localparam int unsigned NX_REG_SENT_S = 'h0C;
    localparam int unsigned NX_REG_SENT_W = 'h10;
    localparam int unsigned NX_REG_DROP   = 'h14;

endpackage : nx_pkg

//--- source/nx_fifo.sv
// ####################
// Synchronous message FIFO
// ####################

module nx_fifo
    import nx_pkg::*;
#(
      parameter int DEPTH = 2
) (
      input  logic        clk_i
    , input  logic        rst_n_i
    // Write side
    , input  nx_message_t wr_data_i
    , input  logic        wr_push_i
    // Read side
    , output nx_message_t rd_data_o
    , input  logic        rd_pop_i
    // Status
    , output logic        empty_o
    , output logic        full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    nx_message_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty_o   = (count == '0);
    assign full_o    = (count == CNT_W'(DEPTH));
    assign do_push   = wr_push_i && !full_o;
    assign do_pop    = rd_pop_i && !empty_o;
    assign rd_data_o = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // Pointers wrap at DEPTH so any depth works
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : nx_fifo

//--- source/nx_route_decoder.sv
// ####################
// Registered route decision with self-address drop
// ####################

module nx_route_decoder
    import nx_pkg::*;
(
      input  logic                  clk_i
    , input  logic                  rst_n_i
    // Inbound message stream
    , input  nx_message_t           in_data_i
    , input  logic                  in_valid_i
    , output logic                  in_ready_o
    // Position of this node
    , input  logic [NX_COORD_W-1:0] node_row_i
    , input  logic [NX_COORD_W-1:0] node_col_i
    // Routed stream towards the distributor
    , output nx_message_t           dist_data_o
    , output nx_direction_t         dist_dir_o
    , output logic                  dist_valid_o
    , input  logic                  dist_ready_i
    // Pulses once per dropped message
    , output logic                  drop_o
);

    nx_direction_t route_dir;
    logic          is_self;
    logic          accept;

    // Columns first, then rows
    always_comb begin
        route_dir = NX_DIRX_NORTH;
        is_self   = 1'b0;
        if (in_data_i.tgt_col > node_col_i) begin
            route_dir = NX_DIRX_EAST;
        end else if (in_data_i.tgt_col < node_col_i) begin
            route_dir = NX_DIRX_WEST;
        end else if (in_data_i.tgt_row < node_row_i) begin
            route_dir = NX_DIRX_NORTH;
        end else if (in_data_i.tgt_row > node_row_i) begin
            route_dir = NX_DIRX_SOUTH;
        end else begin
            is_self = 1'b1;
        end
    end

    // Stage can take a new item while it drains
    assign in_ready_o = !dist_valid_o || dist_ready_i;
    assign accept     = in_valid_i && in_ready_o;
    assign drop_o     = accept && is_self;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dist_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            dist_valid_o <= in_valid_i && !is_self;
        end
    end

    // Payload of the stage
    always_ff @(posedge clk_i) begin
        if (accept && !is_self) begin
            dist_data_o <= in_data_i;
            dist_dir_o  <= route_dir;
        end
    end

endmodule : nx_route_decoder

//--- source/nx_stream_distributor.sv
// ####################
// Steering of routed messages into four egress FIFOs
// with clockwise aliasing of absent neighbours
// ####################

module nx_stream_distributor
    import nx_pkg::*;
#(
      parameter int FIFO_DEPTH = 2
) (
      input  logic          clk_i
    , input  logic          rst_n_i
    // Routed message stream
    , input  nx_message_t   dist_data_i
    , input  nx_direction_t dist_dir_i
    , input  logic          dist_valid_i
    , output logic          dist_ready_o
    // North
    , output nx_message_t   north_data_o
    , output logic          north_valid_o
    , input  logic          north_ready_i
    , input  logic          north_present_i
    // East
    , output nx_message_t   east_data_o
    , output logic          east_valid_o
    , input  logic          east_ready_i
    , input  logic          east_present_i
    // South
    , output nx_message_t   south_data_o
    , output logic          south_valid_o
    , input  logic          south_ready_i
    , input  logic          south_present_i
    // West
    , output nx_message_t   west_data_o
    , output logic          west_valid_o
    , input  logic          west_ready_i
    , input  logic          west_present_i
    // One strobe per output handshake
    , output logic [3:0]    sent_o
);

    nx_message_t            egress_data [NX_NUM_DIRS];
    logic [NX_NUM_DIRS-1:0] egress_ready;
    logic [NX_NUM_DIRS-1:0] egress_present;
    logic [NX_NUM_DIRS-1:0] egress_full;
    logic [NX_NUM_DIRS-1:0] egress_empty;
    logic [NX_NUM_DIRS-1:0] egress_pop;
    logic [1:0]             dir_idx;
    logic [1:0]             target_idx;

    // Gather the loose ports into arrays indexed by direction
    assign egress_ready   = {west_ready_i, south_ready_i, east_ready_i, north_ready_i};
    assign egress_present = {west_present_i, south_present_i, east_present_i, north_present_i};

    assign north_data_o  = egress_data[NX_DIRX_NORTH];
    assign east_data_o   = egress_data[NX_DIRX_EAST];
    assign south_data_o  = egress_data[NX_DIRX_SOUTH];
    assign west_data_o   = egress_data[NX_DIRX_WEST];
    assign north_valid_o = !egress_empty[NX_DIRX_NORTH];
    assign east_valid_o  = !egress_empty[NX_DIRX_EAST];
    assign south_valid_o = !egress_empty[NX_DIRX_SOUTH];
    assign west_valid_o  = !egress_empty[NX_DIRX_WEST];

    assign egress_pop = egress_ready & ~egress_empty;
    assign sent_o     = egress_pop;

    // Absent neighbour hands its traffic to the next one clockwise
    assign dir_idx      = dist_dir_i;
    assign target_idx   = egress_present[dir_idx] ? dir_idx : dir_idx + 2'd1;
    assign dist_ready_o = !egress_full[target_idx];

    for (genvar i = 0; i < NX_NUM_DIRS; i++) begin : g_egress
        logic primary_hit;
        logic alias_hit;
        logic push;

        assign primary_hit = (dist_dir_i == nx_direction_t'(i)) && egress_present[i];
        assign alias_hit   = (dist_dir_i == nx_direction_t'((i + 3) % NX_NUM_DIRS))
                          && !egress_present[(i + 3) % NX_NUM_DIRS];
        assign push        = dist_valid_i && !egress_full[i] && (primary_hit || alias_hit);

        nx_fifo #(
              .DEPTH(FIFO_DEPTH)
        ) u_fifo (
              .clk_i    (clk_i)
            , .rst_n_i  (rst_n_i)
            , .wr_data_i(dist_data_i)
            , .wr_push_i(push)
            , .rd_data_o(egress_data[i])
            , .rd_pop_i (egress_pop[i])
            , .empty_o  (egress_empty[i])
            , .full_o   (egress_full[i])
        );
    end

endmodule : nx_stream_distributor

//--- source/nx_apb_regs.sv
// ####################
// APB registers for node position and traffic counters
// ####################

module nx_apb_regs
    import nx_pkg::*;
#(
      parameter int APB_ADDR_W = 8
) (
      input  logic                     clk_i
    , input  logic                     rst_n_i
    // APB slave
    , input  logic [APB_ADDR_W-1:0]    paddr_i
    , input  logic                     psel_i
    , input  logic                     penable_i
    , input  logic                     pwrite_i
    , input  logic [NX_APB_DATA_W-1:0] pwdata_i
    , output logic [NX_APB_DATA_W-1:0] prdata_o
    , output logic                     pready_o
    , output logic                     pslverr_o
    // Node position
    , output logic [NX_COORD_W-1:0]    node_row_o
    , output logic [NX_COORD_W-1:0]    node_col_o
    // Event strobes
    , input  logic [3:0]               sent_i
    , input  logic                     drop_i
);

    logic [NX_CNT_W-1:0] sent_cnt [NX_NUM_DIRS];
    logic [NX_CNT_W-1:0] drop_cnt;
    logic                access;
    logic                addr_hit;
    logic                read_only;
    logic                pos_wr;

    assign access    = psel_i && penable_i;
    assign pready_o  = 1'b1;
    assign pslverr_o = access && (!addr_hit || (pwrite_i && read_only));
    assign pos_wr    = access && pwrite_i && addr_hit && !read_only;

    // Read mux and address decode
    always_comb begin
        prdata_o  = '0;
        addr_hit  = 1'b1;
        read_only = 1'b1;
        case (paddr_i)
            APB_ADDR_W'(NX_REG_POS): begin
                prdata_o  = NX_APB_DATA_W'({node_col_o, node_row_o});
                read_only = 1'b0;
            end
            APB_ADDR_W'(NX_REG_SENT_N): prdata_o = NX_APB_DATA_W'(sent_cnt[NX_DIRX_NORTH]);
            APB_ADDR_W'(NX_REG_SENT_E): prdata_o = NX_APB_DATA_W'(sent_cnt[NX_DIRX_EAST]);
            APB_ADDR_W'(NX_REG_SENT_S): prdata_o = NX_APB_DATA_W'(sent_cnt[NX_DIRX_SOUTH]);
            APB_ADDR_W'(NX_REG_SENT_W): prdata_o = NX_APB_DATA_W'(sent_cnt[NX_DIRX_WEST]);
            APB_ADDR_W'(NX_REG_DROP):   prdata_o = NX_APB_DATA_W'(drop_cnt);
            default:                    addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            node_row_o <= '0;
            node_col_o <= '0;
            drop_cnt   <= '0;
            for (int k = 0; k < NX_NUM_DIRS; k++) begin
                sent_cnt[k] <= '0;
            end
        end else begin
            if (pos_wr) begin
                node_row_o <= pwdata_i[NX_COORD_W-1:0];
                node_col_o <= pwdata_i[2*NX_COORD_W-1:NX_COORD_W];
            end
            // Counters simply wrap
            for (int k = 0; k < NX_NUM_DIRS; k++) begin
                if (sent_i[k]) begin
                    sent_cnt[k] <= sent_cnt[k] + 1'b1;
                end
            end
            if (drop_i) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

endmodule : nx_apb_regs

//--- source/nx_node_egress.sv
// ####################
// Egress stage of a mesh node
// ####################

module nx_node_egress
    import nx_pkg::*;
#(
      parameter int FIFO_DEPTH = 2
    , parameter int APB_ADDR_W = 8
) (
      input  logic                     clk_i
    , input  logic                     rst_n_i
    // Inbound message stream
    , input  nx_message_t              in_data_i
    , input  logic                     in_valid_i
    , output logic                     in_ready_o
    // Outbound streams
    , output nx_message_t              north_data_o
    , output logic                     north_valid_o
    , input  logic                     north_ready_i
    , input  logic                     north_present_i
    , output nx_message_t              east_data_o
    , output logic                     east_valid_o
    , input  logic                     east_ready_i
    , input  logic                     east_present_i
    , output nx_message_t              south_data_o
    , output logic                     south_valid_o
    , input  logic                     south_ready_i
    , input  logic                     south_present_i
    , output nx_message_t              west_data_o
    , output logic                     west_valid_o
    , input  logic                     west_ready_i
    , input  logic                     west_present_i
    // APB slave
    , input  logic [APB_ADDR_W-1:0]    paddr_i
    , input  logic                     psel_i
    , input  logic                     penable_i
    , input  logic                     pwrite_i
    , input  logic [NX_APB_DATA_W-1:0] pwdata_i
    , output logic [NX_APB_DATA_W-1:0] prdata_o
    , output logic                     pready_o
    , output logic                     pslverr_o
);

    logic [NX_COORD_W-1:0] node_row;
    logic [NX_COORD_W-1:0] node_col;
    nx_message_t           dist_data;
    nx_direction_t         dist_dir;
    logic                  dist_valid;
    logic                  dist_ready;
    logic [3:0]            sent;
    logic                  drop;

    nx_apb_regs #(
          .APB_ADDR_W(APB_ADDR_W)
    ) u_regs (
          .clk_i     (clk_i)
        , .rst_n_i   (rst_n_i)
        , .paddr_i   (paddr_i)
        , .psel_i    (psel_i)
        , .penable_i (penable_i)
        , .pwrite_i  (pwrite_i)
        , .pwdata_i  (pwdata_i)
        , .prdata_o  (prdata_o)
        , .pready_o  (pready_o)
        , .pslverr_o (pslverr_o)
        , .node_row_o(node_row)
        , .node_col_o(node_col)
        , .sent_i    (sent)
        , .drop_i    (drop)
    );

    nx_route_decoder u_decoder (
          .clk_i       (clk_i)
        , .rst_n_i     (rst_n_i)
        , .in_data_i   (in_data_i)
        , .in_valid_i  (in_valid_i)
        , .in_ready_o  (in_ready_o)
        , .node_row_i  (node_row)
        , .node_col_i  (node_col)
        , .dist_data_o (dist_data)
        , .dist_dir_o  (dist_dir)
        , .dist_valid_o(dist_valid)
        , .dist_ready_i(dist_ready)
        , .drop_o      (drop)
    );

    nx_stream_distributor #(
          .FIFO_DEPTH(FIFO_DEPTH)
    ) u_distributor (
          .clk_i          (clk_i)
        , .rst_n_i        (rst_n_i)
        , .dist_data_i    (dist_data)
        , .dist_dir_i     (dist_dir)
        , .dist_valid_i   (dist_valid)
        , .dist_ready_o   (dist_ready)
        , .north_data_o   (north_data_o)
        , .north_valid_o  (north_valid_o)
        , .north_ready_i  (north_ready_i)
        , .north_present_i(north_present_i)
        , .east_data_o    (east_data_o)
        , .east_valid_o   (east_valid_o)
        , .east_ready_i   (east_ready_i)
        , .east_present_i (east_present_i)
        , .south_data_o   (south_data_o)
        , .south_valid_o  (south_valid_o)
        , .south_ready_i  (south_ready_i)
        , .south_present_i(south_present_i)
        , .west_data_o    (west_data_o)
        , .west_valid_o   (west_valid_o)
        , .west_ready_i   (west_ready_i)
        , .west_present_i (west_present_i)
        , .sent_o         (sent)
    );

endmodule : nx_node_egress

//--- testbench/nx_node_egress_chk.sv
// ####################
// Distributor assertions, bound into nx_stream_distributor
// ####################

module nx_node_egress_chk (
      input logic             clk_i
    , input logic             rst_n_i
    , input logic             dist_valid_i
    , input logic             dist_ready_i
    , input logic [1:0]       dir_i
    , input logic [3:0]       present_i
    , input logic [3:0]       full_i
    , input logic [3:0]       valid_i
    , input logic [3:0]       ready_i
    , input logic [3:0][31:0] data_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [1:0] next_cw;
    logic [1:0] expect_idx;

    // Clockwise neighbour of the routed direction
    always_comb begin
        case (dir_i)
            2'd0:    next_cw = 2'd1;
            2'd1:    next_cw = 2'd2;
            2'd2:    next_cw = 2'd3;
            default: next_cw = 2'd0;
        endcase
    end

    // FIFO that should take the message
    assign expect_idx = present_i[dir_i] ? dir_i : next_cw;

    // Accepted message must land in a FIFO with room
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dist_valid_i && dist_ready_i |-> !full_i[expect_idx])
        else $error("message pushed into a full egress FIFO");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        full_i[expect_idx] |-> !dist_ready_i)
        else $error("distributor ready while its target FIFO is full");

    // Held outputs keep valid and data
    for (genvar d = 0; d < 4; d++) begin : g_hold
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            valid_i[d] && !ready_i[d] |=> valid_i[d] && $stable(data_i[d]))
            else $error("egress output %0d changed before ready", d);
    end

endmodule : nx_node_egress_chk

bind nx_stream_distributor nx_node_egress_chk u_chk (
      .clk_i       (clk_i)
    , .rst_n_i     (rst_n_i)
    , .dist_valid_i(dist_valid_i)
    , .dist_ready_i(dist_ready_o)
    , .dir_i       (dist_dir_i)
    , .present_i   (egress_present)
    , .full_i      (egress_full)
    , .valid_i     (~egress_empty)
    , .ready_i     (egress_ready)
    , .data_i      ({west_data_o, south_data_o, east_data_o, north_data_o})
);

//--- testbench/tb_nx_node_egress.sv
// ####################
// Testbench for the mesh node egress stage
// File-driven stimulus, output monitors, APB tasks
// ####################

module tb_nx_node_egress
    import nx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    logic        clk;
    logic        rst_n;
    nx_message_t in_data;
    logic        in_valid;
    logic        in_ready;
    nx_message_t out_data [4];
    logic [3:0]  out_valid;
    logic [3:0]  rdy = 4'hf;
    logic [3:0]  present;
    logic [3:0]  stall_mask;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed = 32'hfbd5_68f6;
    logic [31:0] exp_q [4][$];
    int          obs_sent [4];
    int          drop_exp;
    int          checks;
    int          errors;
    int          n_tests;
    int          test_err_base;
    bit          timed_out;
    string       test_name;
    string       dir_name [4] = '{"north", "east", "south", "west"};

    nx_node_egress #(
          .FIFO_DEPTH(2)
        , .APB_ADDR_W(8)
    ) uut (
          .clk_i          (clk)
        , .rst_n_i        (rst_n)
        , .in_data_i      (in_data)
        , .in_valid_i     (in_valid)
        , .in_ready_o     (in_ready)
        , .north_data_o   (out_data[0])
        , .north_valid_o  (out_valid[0])
        , .north_ready_i  (rdy[0])
        , .north_present_i(present[0])
        , .east_data_o    (out_data[1])
        , .east_valid_o   (out_valid[1])
        , .east_ready_i   (rdy[1])
        , .east_present_i (present[1])
        , .south_data_o   (out_data[2])
        , .south_valid_o  (out_valid[2])
        , .south_ready_i  (rdy[2])
        , .south_present_i(present[2])
        , .west_data_o    (out_data[3])
        , .west_valid_o   (out_valid[3])
        , .west_ready_i   (rdy[3])
        , .west_present_i (present[3])
        , .paddr_i        (paddr)
        , .psel_i         (psel)
        , .penable_i      (penable)
        , .pwrite_i       (pwrite)
        , .pwdata_i       (pwdata)
        , .prdata_o       (prdata)
        , .pready_o       (pready)
        , .pslverr_o      (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic flag_timeout(input string why);
        $display("timeout at %0t ns: %s", $time, why);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic close_test();
        if (test_name != "") begin
            if (errors == test_err_base) begin
                $display("test %s: ok", test_name);
            end else begin
                $display("test %s: %0d errors", test_name, errors - test_err_base);
            end
        end
    endtask

    // Random stalls only on the outputs selected by the stall mask
    always @(negedge clk) begin
        for (int d = 0; d < 4; d++) begin
            rdy[d] = stall_mask[d] ? (($random(seed) % 3) != 0) : 1'b1;
        end
    end

    // Every output handshake must match the head of its queue
    always @(posedge clk) begin
        if (rst_n) begin
            for (int d = 0; d < 4; d++) begin
                if (out_valid[d] && rdy[d]) begin
                    obs_sent[d]++;
                    if (exp_q[d].size() == 0) begin
                        errors++;
                        $display("unexpected message %h appeared on output %s at %0t ns",
                                 out_data[d], dir_name[d], $time);
                    end else begin
                        check($sformatf("%s_data_o", dir_name[d]), exp_q[d].pop_front(),
                              out_data[d]);
                    end
                end
            end
        end
    end

    // Setup phase, then access phase, sampled before the completing edge
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        #1;
        while (!pready && waited < TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!pready) begin
            flag_timeout("APB slave never raised pready");
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_msg(input logic [31:0] word);
        int waited;
        in_data  = word;
        in_valid = 1'b1;
        waited   = 0;
        #1;
        while (!in_ready && waited < TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!in_ready) begin
            flag_timeout("inbound stream never became ready");
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        int pending;
        waited  = 0;
        pending = 1;
        while (pending != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            pending = 0;
            for (int d = 0; d < 4; d++) begin
                pending += exp_q[d].size();
            end
        end
        for (int d = 0; d < 4; d++) begin
            if (exp_q[d].size() != 0) begin
                flag_timeout($sformatf("output %s never delivered its expected messages",
                                       dir_name[d]));
            end
        end
    endtask

    initial begin
        string       op;
        string       skipped;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_err;
        logic [31:0] rd_data;
        logic        rd_err;
        int          dir;
        int          fd;
        in_data    = '0;
        in_valid   = 1'b0;
        present    = 4'hf;
        stall_mask = 4'h0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        rst_n      = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("testbench/stimulus_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            errors++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", op) == 1) begin
                case (op)
                    "#": begin
                        void'($fgets(skipped, fd));
                    end
                    "test": begin
                        close_test();
                        void'($fscanf(fd, "%s", test_name));
                        test_err_base = errors;
                        n_tests++;
                    end
                    "write", "read": begin
                        void'($fscanf(fd, "%h %h %h", f_addr, f_data, f_err));
                        apb_access(op == "write", f_addr[7:0], f_data, rd_data, rd_err);
                        if (op == "read") begin
                            check("prdata_o", f_data, rd_data);
                        end
                        check("pslverr_o", f_err, {31'b0, rd_err});
                    end
                    "present": begin
                        void'($fscanf(fd, "%h", f_data));
                        present = f_data[3:0];
                    end
                    "stall": begin
                        void'($fscanf(fd, "%h", f_data));
                        stall_mask = f_data[3:0];
                    end
                    "msg": begin
                        void'($fscanf(fd, "%h %d", f_data, dir));
                        if (dir == 4) begin
                            drop_exp++;
                        end else begin
                            exp_q[dir].push_back(f_data);
                        end
                        send_msg(f_data);
                    end
                    "drain": drain();
                    "idle": begin
                        check("output valids", 32'h0, {28'b0, out_valid});
                        check("in_ready_o", 32'h1, {31'b0, in_ready});
                    end
                    // SENT registers against handshakes seen by the monitor
                    "counters": begin
                        for (int d = 0; d < 4; d++) begin
                            apb_access(1'b0, 8'(NX_REG_SENT_N + 4 * d), '0, rd_data, rd_err);
                            check($sformatf("sent_%s", dir_name[d]), obs_sent[d], rd_data);
                        end
                        apb_access(1'b0, 8'(NX_REG_DROP), '0, rd_data, rd_err);
                        check("drop count", drop_exp, rd_data);
                    end
                    default: begin
                        $display("unknown operation %s in the stimulus file", op);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end
        close_test();
        $display("tests: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : tb_nx_node_egress

//--- testbench/stimulus_input.txt
# Columns: op then hex fields; write/read addr data slverr; present/stall mask (bit 0 north)
# msg word dir: row[31:28] col[27:24] payload[23:0], dir 0..3 is N E S W, 4 is dropped
test reset_state
idle
read 00 00000000 0
read 04 00000000 0
read 08 00000000 0
read 0c 00000000 0
read 10 00000000 0
read 14 00000000 0
test routing
write 00 00000022 0
read 00 00000022 0
msg 12000001 0
msg 23000002 1
msg 32000003 2
msg 21000004 3
msg 05000005 1
msg f0000006 3
drain
test aliasing
present a
msg 12000011 1
msg 32000012 3
msg 23000013 1
msg 02000014 1
msg 42000015 3
drain
test drops
present f
msg 22000021 4
msg 22000022 4
msg 23000023 1
msg 22000024 4
drain
read 14 00000003 0
test backpressure
stall f
msg 12000031 0
msg 23000032 1
msg 32000033 2
msg 21000034 3
msg 12000035 0
msg 12000036 0
msg 13000037 1
msg 33000038 1
msg 31000039 3
msg 42000040 2
msg 02000041 0
msg 22000042 4
msg 52000043 2
msg 20000044 3
drain
test apb_counters
stall 0
counters
read 18 00000000 1
write 04 00001234 1
counters

//--- tb.f
source/nx_pkg.sv
source/nx_fifo.sv
source/nx_route_decoder.sv
source/nx_stream_distributor.sv
source/nx_apb_regs.sv
source/nx_node_egress.sv
testbench/nx_node_egress_chk.sv
testbench/tb_nx_node_egress.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log and scan the log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_nx_node_egress -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && ! grep -q "tests failed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
